//--- bench/tb_wb_tasks.svh
// ============================================================
// Wishbone master
// ============================================================
// Every task here starts and ends on a falling edge

task automatic wait_ack(input int latency);
  int n;
  n = 0;
  do begin
    @(negedge clk);
    n++;
  end while (wb_ack !== 1'b1 && n < ACK_LIMIT);
  if (wb_ack !== 1'b1) begin
    $display("Checks failed");
    $fatal(1, "No wb_ack within %0d cycles of stb", ACK_LIMIT);
  end
  check_val("wb_ack latency", 32'(n), 32'(latency));
endtask

// Request is held through the acked clock, then released
task automatic bus_xfer(input logic we, input wb_adr_t adr, input wb_data_t wdata,
                        output wb_data_t rdata);
  wb_cyc   = 1'b1;
  wb_stb   = 1'b1;
  wb_we    = we;
  wb_adr   = adr;
  wb_dat_w = wdata;
  wait_ack(we ? 1 : 2);
  rdata = wb_dat_r;
  @(negedge clk);
  // Single-cycle ack
  check_val("wb_ack", 32'(wb_ack), 32'h0);
  wb_cyc = 1'b0;
  wb_stb = 1'b0;
endtask

// ============================================================
// Compute ports
// ============================================================
// Both layers get random addresses, only the selected one counts
task automatic drive_input_addrs(input logic sel, output int h_a, output int node_a,
                                 output int wgt_a);
  layer_sel    = sel;
  l0_h_addr    = H_AW'($urandom());
  l1_h_addr    = H_AW'($urandom());
  l0_node_addr = NODE_AW'($urandom());
  l1_node_addr = NODE_AW'($urandom());
  l0_wgt_addr  = WGT_AW'($urandom());
  l1_wgt_addr  = WGT_AW'($urandom());
  h_a    = int'(sel ? l1_h_addr : l0_h_addr);
  node_a = int'(sel ? l1_node_addr : l0_node_addr);
  wgt_a  = int'(sel ? l1_wgt_addr : l0_wgt_addr);
endtask

task automatic drive_feat_random(output logic we, output int addr, output feat_t din);
  layer_sel    = 1'($urandom());
  l0_feat_we   = 1'($urandom());
  l1_feat_we   = 1'($urandom());
  l0_feat_addr = FEAT_AW'($urandom());
  l1_feat_addr = FEAT_AW'($urandom());
  l0_feat_din  = $urandom();
  l1_feat_din  = $urandom();
  we   = layer_sel ? l1_feat_we : l0_feat_we;
  addr = int'(layer_sel ? l1_feat_addr : l0_feat_addr);
  din  = layer_sel ? l1_feat_din : l0_feat_din;
endtask

//--- bench/tb_gat_mem.sv
`timescale 1ns/1ns

module tb_gat_mem import gat_mem_pkg::*; ();

  localparam int H_DEPTH    = 256;
  localparam int NODE_DEPTH = 64;
  localparam int WGT_DEPTH  = 128;
  localparam int FEAT_DEPTH = 64;
  localparam int H_AW       = $clog2(H_DEPTH);
  localparam int NODE_AW    = $clog2(NODE_DEPTH);
  localparam int WGT_AW     = $clog2(WGT_DEPTH);
  localparam int FEAT_AW    = $clog2(FEAT_DEPTH);

  localparam int ACK_LIMIT = 4;
  localparam int N_REWRITE = 40;
  localparam int N_READS   = 200;
  localparam int N_FEAT    = 200;
  localparam int N_MISC    = 16;

  // Bus write takes 2 cycles, bus read 3, compute access 1
  localparam int RUN_CYCLES = 4 + 2 * (H_DEPTH + NODE_DEPTH + WGT_DEPTH + 3 * N_REWRITE)
    + 2 * (N_READS + 1) + FEAT_DEPTH + N_FEAT + 3 * FEAT_DEPTH + 8 * N_MISC;
  localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;

  logic               clk          = 1'b0;
  logic               reset        = 1'b1;
  logic               wb_cyc       = 1'b0;
  logic               wb_stb       = 1'b0;
  logic               wb_we        = 1'b0;
  wb_adr_t            wb_adr       = '0;
  wb_data_t           wb_dat_w     = '0;
  wb_data_t           wb_dat_r;
  logic               wb_ack;
  logic               layer_sel    = 1'b0;
  logic [H_AW-1:0]    l0_h_addr    = '0;
  logic [H_AW-1:0]    l1_h_addr    = '0;
  logic [NODE_AW-1:0] l0_node_addr = '0;
  logic [NODE_AW-1:0] l1_node_addr = '0;
  logic [WGT_AW-1:0]  l0_wgt_addr  = '0;
  logic [WGT_AW-1:0]  l1_wgt_addr  = '0;
  h_word_t            h_dout;
  node_info_t         node_dout;
  weight_t            wgt_dout;
  logic               l0_feat_we   = 1'b0;
  logic               l1_feat_we   = 1'b0;
  logic [FEAT_AW-1:0] l0_feat_addr = '0;
  logic [FEAT_AW-1:0] l1_feat_addr = '0;
  feat_t              l0_feat_din  = '0;
  feat_t              l1_feat_din  = '0;
  int                 cycles       = 0;

  // Reference copies of the four memories
  h_word_t    h_model    [int];
  node_info_t node_model [int];
  weight_t    wgt_model  [int];
  feat_t      feat_model [int];

  gat_mem_top #(
    .H_DEPTH (H_DEPTH), .NODE_DEPTH (NODE_DEPTH),
    .WGT_DEPTH (WGT_DEPTH), .FEAT_DEPTH (FEAT_DEPTH)
  ) dut0 (.*);

  always #4 clk = ~clk;

  // Limit is twice the expected length of the test sequence
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Checks failed");
      $fatal(1, "Timeout after %0d cycles", cycles);
    end
  end

  task automatic check_val(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("Checks failed");
      $fatal(1, "Mismatch on %s at %0t", name, $time);
    end
  endtask

  `include "tb_wb_tasks.svh"

  task automatic load_word(input region_t region, input int offset);
    wb_data_t data;
    wb_data_t rd;
    data = $urandom();
    bus_xfer(1'b1, {region, 8'(offset)}, data, rd);
    // Each memory keeps the low bits of the bus word
    case (region)
      REG_H:    h_model[offset]    = data[15:0];
      REG_NODE: node_model[offset] = data[11:0];
      default:  wgt_model[offset]  = data[7:0];
    endcase
  endtask

  // Outputs are checked one clock after their address
  task automatic input_read_phase(input logic sel, input int n);
    int h_a;
    int node_a;
    int wgt_a;
    for (int i = 0; i <= n; i++) begin
      if (i > 0) begin
        check_val("h_dout", 32'(h_dout), 32'(h_model[h_a]));
        check_val("node_dout", 32'(node_dout), 32'(node_model[node_a]));
        check_val("wgt_dout", 32'(wgt_dout), 32'(wgt_model[wgt_a]));
      end
      check_val("wb_ack", 32'(wb_ack), 32'h0);
      drive_input_addrs(sel, h_a, node_a, wgt_a);
      @(negedge clk);
    end
  endtask

  initial begin
    wb_data_t rd;
    region_t  region;
    int       offset;
    logic     we;
    feat_t    din;
    void'($urandom(88081));
    repeat (4) @(negedge clk);
    reset = 1'b0;

    // ==========================================================
    // Input memories
    // ==========================================================
    for (int i = 0; i < H_DEPTH; i++) begin
      load_word(REG_H, i);
      if (i < NODE_DEPTH) begin
        load_word(REG_NODE, i);
      end
      if (i < WGT_DEPTH) begin
        load_word(REG_WGT, i);
      end
    end
    for (int i = 0; i < N_REWRITE; i++) begin
      load_word(REG_H, $urandom_range(H_DEPTH - 1, 0));
      load_word(REG_NODE, $urandom_range(NODE_DEPTH - 1, 0));
      load_word(REG_WGT, $urandom_range(WGT_DEPTH - 1, 0));
    end
    input_read_phase(1'b0, N_READS);
    input_read_phase(1'b1, N_READS);

    // ==========================================================
    // Feature memory
    // ==========================================================
    layer_sel  = 1'b0;
    l0_feat_we = 1'b1;
    for (int i = 0; i < FEAT_DEPTH; i++) begin
      l0_feat_addr  = FEAT_AW'(i);
      l0_feat_din   = $urandom();
      feat_model[i] = l0_feat_din;
      @(negedge clk);
    end
    for (int i = 0; i < N_FEAT; i++) begin
      check_val("wb_ack", 32'(wb_ack), 32'h0);
      drive_feat_random(we, offset, din);
      if (we) begin
        feat_model[offset] = din;
      end
      @(negedge clk);
    end
    l0_feat_we = 1'b0;
    l1_feat_we = 1'b0;
    for (int i = 0; i < FEAT_DEPTH; i++) begin
      bus_xfer(1'b0, {REG_FEAT, 8'(i)}, '0, rd);
      check_val("wb_dat_r", rd, feat_model[i]);
    end

    // Bus writes to features are ignored
    for (int i = 0; i < N_MISC; i++) begin
      offset = $urandom_range(FEAT_DEPTH - 1, 0);
      bus_xfer(1'b1, {REG_FEAT, 8'(offset)}, $urandom(), rd);
      bus_xfer(1'b0, {REG_FEAT, 8'(offset)}, '0, rd);
      check_val("wb_dat_r", rd, feat_model[offset]);
    end
    // Load regions read back as zero
    for (int i = 0; i < N_MISC; i++) begin
      region = region_t'(2'($urandom_range(2, 0)));
      bus_xfer(1'b0, {region, 8'($urandom())}, '0, rd);
      check_val("wb_dat_r", rd, 32'h0);
    end

    $display("All checks passed");
    $finish;
  end

endmodule

//--- gat_mem.f
+incdir+bench
rtl/gat_mem_pkg.sv
rtl/mem_load_if.sv
rtl/bram_sdp.sv
rtl/wb_mem_slave.sv
rtl/input_banks.sv
rtl/feat_bank.sv
rtl/gat_mem_top.sv
bench/tb_gat_mem.sv

//--- rtl/bram_sdp.sv
`timescale 1ns/1ns

module bram_sdp import gat_mem_pkg::*; #(
  parameter  int WIDTH = 8,
  parameter  int DEPTH = 256,
  localparam int AW    = addr_w(DEPTH)
) (
  input  logic             clk,
  input  logic             we,
  input  logic [AW-1:0]    waddr,
  input  logic [WIDTH-1:0] wdata,
  input  logic [AW-1:0]    raddr,
  output logic [WIDTH-1:0] rdata
);

  logic [WIDTH-1:0] mem [DEPTH];

  // Read-first on a same-address collision
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

  // Writers must keep inside the array, also for non-power-of-two depths
  a_waddr_in_range: assert property (
    @(posedge clk) we |-> (int'(waddr) < DEPTH)
  ) else $error("bram_sdp write address %0d beyond depth %0d", waddr, DEPTH);

endmodule

//--- rtl/feat_bank.sv
`timescale 1ns/1ns

module feat_bank import gat_mem_pkg::*; #(
  parameter  int FEAT_DEPTH = 64,
  localparam int FEAT_AW    = addr_w(FEAT_DEPTH)
) (
  input  logic               clk,
  input  logic               layer_sel,

  mem_load_if.mem_mp         load,

  input  logic               l0_feat_we,
  input  logic               l1_feat_we,
  input  logic [FEAT_AW-1:0] l0_feat_addr,
  input  logic [FEAT_AW-1:0] l1_feat_addr,
  input  feat_t              l0_feat_din,
  input  feat_t              l1_feat_din
);

  logic               feat_we;
  logic [FEAT_AW-1:0] feat_waddr;
  feat_t              feat_wdata;

  // Write port belongs to the active layer only
  assign feat_we    = layer_sel ? l1_feat_we   : l0_feat_we;
  assign feat_waddr = layer_sel ? l1_feat_addr : l0_feat_addr;
  assign feat_wdata = layer_sel ? l1_feat_din  : l0_feat_din;

  // Read port is the processor's readback
  bram_sdp #(.WIDTH($bits(feat_t)), .DEPTH(FEAT_DEPTH)) u_feat_bram (
    .clk   (clk),
    .we    (feat_we),
    .waddr (feat_waddr),
    .wdata (feat_wdata),
    .raddr (load.feat_rd_offset[FEAT_AW-1:0]),
    .rdata (load.feat_rd_data)
  );

endmodule

//--- rtl/gat_mem_pkg.sv
package gat_mem_pkg;

  // ==========================================================
  // Word types
  // ==========================================================
  // Value in [15:8], column index in [7:0]
  typedef logic [15:0] h_word_t;

  // Row length, neighbour count and flag, packed
  typedef logic [11:0] node_info_t;

  typedef logic [7:0]  weight_t;
  typedef logic [31:0] feat_t;

  // Bus side
  typedef logic [31:0] wb_data_t;
  typedef logic [9:0]  wb_adr_t;

  // ==========================================================
  // Address map
  // ==========================================================
  // Word address = {region, offset}
  localparam int OFFSET_W   = 8;
  localparam int REGION_LSB = OFFSET_W;
  localparam int REGION_MSB = REGION_LSB + 1;

  // Widest word loaded by the processor
  localparam int LOAD_W = $bits(h_word_t);

  typedef enum logic [1:0] {
    REG_H    = 2'd0,
    REG_NODE = 2'd1,
    REG_WGT  = 2'd2,
    REG_FEAT = 2'd3
  } region_t;

  typedef enum logic [1:0] {
    WB_IDLE = 2'd0,
    WB_WAIT = 2'd1,
    WB_ACK  = 2'd2
  } wb_state_t;

  // RAM address width for a given depth
  function automatic int addr_w(input int depth);
    return (depth > 1) ? $clog2(depth) : 1;
  endfunction

endpackage

//--- rtl/gat_mem_top.sv
`timescale 1ns/1ns

module gat_mem_top import gat_mem_pkg::*; #(
  parameter  int H_DEPTH    = 256,
  parameter  int NODE_DEPTH = 64,
  parameter  int WGT_DEPTH  = 128,
  parameter  int FEAT_DEPTH = 64,
  localparam int H_AW       = addr_w(H_DEPTH),
  localparam int NODE_AW    = addr_w(NODE_DEPTH),
  localparam int WGT_AW     = addr_w(WGT_DEPTH),
  localparam int FEAT_AW    = addr_w(FEAT_DEPTH)
) (
  input  logic               clk,
  input  logic               reset,

  // ==========================================================
  // Processor bus
  // ==========================================================
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  logic               wb_we,
  input  wb_adr_t            wb_adr,
  input  wb_data_t           wb_dat_w,
  output wb_data_t           wb_dat_r,
  output logic               wb_ack,

  // ==========================================================
  // Compute layers
  // ==========================================================
  input  logic               layer_sel,

  input  logic [H_AW-1:0]    l0_h_addr,
  input  logic [H_AW-1:0]    l1_h_addr,
  input  logic [NODE_AW-1:0] l0_node_addr,
  input  logic [NODE_AW-1:0] l1_node_addr,
  input  logic [WGT_AW-1:0]  l0_wgt_addr,
  input  logic [WGT_AW-1:0]  l1_wgt_addr,
  output h_word_t            h_dout,
  output node_info_t         node_dout,
  output weight_t            wgt_dout,

  input  logic               l0_feat_we,
  input  logic               l1_feat_we,
  input  logic [FEAT_AW-1:0] l0_feat_addr,
  input  logic [FEAT_AW-1:0] l1_feat_addr,
  input  feat_t              l0_feat_din,
  input  feat_t              l1_feat_din
);

  mem_load_if u_load ();

  wb_mem_slave u_wb_slave (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .load     (u_load.slave_mp)
  );

  input_banks #(
    .H_DEPTH    (H_DEPTH),
    .NODE_DEPTH (NODE_DEPTH),
    .WGT_DEPTH  (WGT_DEPTH)
  ) u_input_banks (
    .clk          (clk),
    .layer_sel    (layer_sel),
    .load         (u_load.mem_mp),
    .l0_h_addr    (l0_h_addr),
    .l1_h_addr    (l1_h_addr),
    .l0_node_addr (l0_node_addr),
    .l1_node_addr (l1_node_addr),
    .l0_wgt_addr  (l0_wgt_addr),
    .l1_wgt_addr  (l1_wgt_addr),
    .h_dout       (h_dout),
    .node_dout    (node_dout),
    .wgt_dout     (wgt_dout)
  );

  feat_bank #(.FEAT_DEPTH(FEAT_DEPTH)) u_feat_bank (
    .clk          (clk),
    .layer_sel    (layer_sel),
    .load         (u_load.mem_mp),
    .l0_feat_we   (l0_feat_we),
    .l1_feat_we   (l1_feat_we),
    .l0_feat_addr (l0_feat_addr),
    .l1_feat_addr (l1_feat_addr),
    .l0_feat_din  (l0_feat_din),
    .l1_feat_din  (l1_feat_din)
  );

endmodule

//--- rtl/input_banks.sv
`timescale 1ns/1ns

module input_banks import gat_mem_pkg::*; #(
  parameter  int H_DEPTH    = 256,
  parameter  int NODE_DEPTH = 64,
  parameter  int WGT_DEPTH  = 128,
  localparam int H_AW       = addr_w(H_DEPTH),
  localparam int NODE_AW    = addr_w(NODE_DEPTH),
  localparam int WGT_AW     = addr_w(WGT_DEPTH)
) (
  input  logic               clk,
  input  logic               layer_sel,

  mem_load_if.mem_mp         load,

  input  logic [H_AW-1:0]    l0_h_addr,
  input  logic [H_AW-1:0]    l1_h_addr,
  input  logic [NODE_AW-1:0] l0_node_addr,
  input  logic [NODE_AW-1:0] l1_node_addr,
  input  logic [WGT_AW-1:0]  l0_wgt_addr,
  input  logic [WGT_AW-1:0]  l1_wgt_addr,

  output h_word_t            h_dout,
  output node_info_t         node_dout,
  output weight_t            wgt_dout
);

  logic [H_AW-1:0]    h_raddr;
  logic [NODE_AW-1:0] node_raddr;
  logic [WGT_AW-1:0]  wgt_raddr;
  logic               h_we;
  logic               node_we;
  logic               wgt_we;

  // Compute side reads, one layer at a time
  assign h_raddr    = layer_sel ? l1_h_addr    : l0_h_addr;
  assign node_raddr = layer_sel ? l1_node_addr : l0_node_addr;
  assign wgt_raddr  = layer_sel ? l1_wgt_addr  : l0_wgt_addr;

  // Bus offsets past the bank depth are dropped, not aliased
  assign h_we    = load.h_we    && (int'(load.wr_offset) < H_DEPTH);
  assign node_we = load.node_we && (int'(load.wr_offset) < NODE_DEPTH);
  assign wgt_we  = load.wgt_we  && (int'(load.wr_offset) < WGT_DEPTH);

  bram_sdp #(.WIDTH($bits(h_word_t)), .DEPTH(H_DEPTH)) u_h_bram (
    .clk   (clk),
    .we    (h_we),
    .waddr (load.wr_offset[H_AW-1:0]),
    .wdata (load.wr_data),
    .raddr (h_raddr),
    .rdata (h_dout)
  );

  bram_sdp #(.WIDTH($bits(node_info_t)), .DEPTH(NODE_DEPTH)) u_node_bram (
    .clk   (clk),
    .we    (node_we),
    .waddr (load.wr_offset[NODE_AW-1:0]),
    .wdata (load.wr_data[$bits(node_info_t)-1:0]),
    .raddr (node_raddr),
    .rdata (node_dout)
  );

  bram_sdp #(.WIDTH($bits(weight_t)), .DEPTH(WGT_DEPTH)) u_wgt_bram (
    .clk   (clk),
    .we    (wgt_we),
    .waddr (load.wr_offset[WGT_AW-1:0]),
    .wdata (load.wr_data[$bits(weight_t)-1:0]),
    .raddr (wgt_raddr),
    .rdata (wgt_dout)
  );

endmodule

//--- rtl/mem_load_if.sv
`timescale 1ns/1ns

interface mem_load_if import gat_mem_pkg::*; ();

  // Processor writes, one enable per load region
  logic                h_we;
  logic                node_we;
  logic                wgt_we;
  logic [OFFSET_W-1:0] wr_offset;
  logic [LOAD_W-1:0]   wr_data;

  // Feature readback path
  logic [OFFSET_W-1:0] feat_rd_offset;
  feat_t               feat_rd_data;

  modport slave_mp (
    output h_we,
    output node_we,
    output wgt_we,
    output wr_offset,
    output wr_data,
    output feat_rd_offset,
    input  feat_rd_data
  );

  modport mem_mp (
    input  h_we,
    input  node_we,
    input  wgt_we,
    input  wr_offset,
    input  wr_data,
    input  feat_rd_offset,
    output feat_rd_data
  );

endinterface

//--- rtl/wb_mem_slave.sv
`timescale 1ns/1ns

module wb_mem_slave import gat_mem_pkg::*; (
  input  logic     clk,
  input  logic     reset,

  input  logic     wb_cyc,
  input  logic     wb_stb,
  input  logic     wb_we,
  input  wb_adr_t  wb_adr,
  input  wb_data_t wb_dat_w,
  output wb_data_t wb_dat_r,
  output logic     wb_ack,

  mem_load_if.slave_mp load
);

  wb_state_t state;
  wb_state_t state_next;
  region_t   region;
  logic      req;
  logic      start;

  assign region = region_t'(wb_adr[REGION_MSB:REGION_LSB]);
  assign req    = wb_cyc && wb_stb;
  assign start  = (state == WB_IDLE) && req;

  // ==========================================================
  // Bus FSM
  // ==========================================================
  // Writes go straight to ACK while reads spend one cycle in WAIT
  // so the feature RAM output has settled
  always_comb begin
    state_next = state;
    case (state)
      WB_IDLE: begin
        if (req) begin
          state_next = wb_we ? WB_ACK : WB_WAIT;
        end
      end
      WB_WAIT: begin
        // Read dropped when the master gives up
        state_next = req ? WB_ACK : WB_IDLE;
      end
      WB_ACK: begin
        state_next = WB_IDLE;
      end
      default: begin
        state_next = WB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= WB_IDLE;
    end else begin
      state <= state_next;
    end
  end

  assign wb_ack = (state == WB_ACK);

  // ==========================================================
  // Load steering
  // ==========================================================
  // Enables fire on the edge that raises ack
  // No enable for the feature region
  assign load.h_we    = start && wb_we && (region == REG_H);
  assign load.node_we = start && wb_we && (region == REG_NODE);
  assign load.wgt_we  = start && wb_we && (region == REG_WGT);

  assign load.wr_offset      = wb_adr[OFFSET_W-1:0];
  assign load.wr_data        = wb_dat_w[LOAD_W-1:0];
  assign load.feat_rd_offset = wb_adr[OFFSET_W-1:0];

  // Only the feature region reads back
  assign wb_dat_r = (wb_ack && !wb_we && (region == REG_FEAT)) ?
                    wb_data_t'(load.feat_rd_data) : '0;

  // ==========================================================
  // Protocol checks
  // ==========================================================
  // Master has to hold cyc and stb through the acked cycle
  a_ack_in_cycle: assert property (
    @(posedge clk) disable iff (reset) wb_ack |-> (wb_cyc && wb_stb)
  ) else $error("wb_ack high outside a bus cycle");

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the gat_mem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_gat_mem -f gat_mem.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed" >&2
  exit 1
fi

./obj_dir/Vtb_gat_mem
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status" >&2
  exit $status
fi
exit 0
